// File: filelist.f
+incdir+src
src/uart_echo_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/echo_fifo.sv
src/uart_tx.sv
src/uart_echo_top.sv
testbench/tb_uart_echo.sv

// File: run_sim.sh
#!/bin/sh
# build and run the uart echo testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_uart_echo \
	-f filelist.f -o sim_uart_echo
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_uart_echo > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: src/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_defs.svh"

module baud_tick_gen
(
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	localparam int N  = `UART_CLKS_PER_TICK;
	localparam int CW = ($clog2(N) > 0) ? $clog2(N) : 1;   // keep at least one bit

	logic [CW-1:0] clk_cnt;   // shared phase for rx and tx

	// free running divider, wraps at N-1
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			clk_cnt <= '0;
			tick    <= 1'b0;
		end
		else if (clk_cnt == CW'(N - 1))
		begin
			clk_cnt <= '0;
			tick    <= 1'b1;   // one clock wide
		end
		else
		begin
			clk_cnt <= clk_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/echo_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module echo_fifo
#(
	parameter int DEPTH = 4
)
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wr,        // write strobe from rx
	input  uart_echo_pkg::uart_byte_t wr_data,
	input  logic                      rd,        // pop strobe from tx
	output uart_echo_pkg::uart_byte_t rd_data,   // oldest entry
	output logic                      empty,
	output logic                      overrun    // write while full, one clock
);
	import uart_echo_pkg::*;

	localparam int PW = ($clog2(DEPTH) > 0) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	uart_byte_t    mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;    // occupancy
	logic          full;
	logic          do_wr;
	logic          do_rd;

	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;    // dropped when full
	assign do_rd = rd && !empty;

	////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			overrun <= 1'b0;
		end
		else
		begin
			overrun <= wr && full;   // registered, next cycle
			if (do_wr)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	assign rd_data = mem[rd_ptr];   // visible the clock after write

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// transmitter must look at empty before popping
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rd |-> !empty);

endmodule

`default_nettype wire

// File: src/uart_echo_defs.svh
`ifndef UART_ECHO_DEFS_SVH
`define UART_ECHO_DEFS_SVH

////////////////////////////////////////////////////////////
// serial timing
////////////////////////////////////////////////////////////

// clk cycles per oversampling tick
`define UART_CLKS_PER_TICK 4

// oversampling ticks per serial bit, 16x
`define UART_TICKS_PER_BIT 16

////////////////////////////////////////////////////////////
// frame and buffer sizes
////////////////////////////////////////////////////////////

`define UART_DATA_BITS 8      // data bits per frame, lsb first
`define UART_FIFO_DEPTH 4     // echo fifo entries

`endif

// File: src/uart_echo_pkg.sv
`default_nettype none

`include "uart_echo_defs.svh"

package uart_echo_pkg;

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////

	// one data byte, as received or sent
	typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

	////////////////////////////////////////////////////////////
	// state encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		RX_IDLE  = 2'b00,   // waiting for falling edge
		RX_START = 2'b01,   // counting to mid start bit
		RX_DATA  = 2'b10,   // sampling data bits
		RX_STOP  = 2'b11    // sampling stop bit
	} rx_state_t;

	typedef enum logic [1:0]
	{
		TX_IDLE  = 2'b00,   // line high, waiting for fifo data
		TX_START = 2'b01,
		TX_DATA  = 2'b10,
		TX_STOP  = 2'b11
	} tx_state_t;

endpackage

`default_nettype wire

// File: src/uart_echo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_defs.svh"

module uart_echo_top
(
	input  logic clk,
	input  logic rst_n,
	input  logic rx,          // serial in
	input  logic cts_n,       // flow control, active low
	output logic tx,          // serial echo out
	output logic frame_err,
	output logic overrun
);
	import uart_echo_pkg::*;

	logic       tick;        // shared 16x strobe
	uart_byte_t rx_data;
	logic       rx_done;
	uart_byte_t fifo_data;
	logic       fifo_empty;
	logic       fifo_pop;

	////////////////////////////////////////////////////////////
	// rx -> fifo -> tx
	////////////////////////////////////////////////////////////

	baud_tick_gen u_baud_tick_gen
	(
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	uart_rx u_uart_rx
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.rx        (rx),
		.rx_data   (rx_data),
		.rx_done   (rx_done),
		.frame_err (frame_err)
	);

	echo_fifo #(.DEPTH(`UART_FIFO_DEPTH)) u_echo_fifo
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (rx_done),
		.wr_data (rx_data),
		.rd      (fifo_pop),
		.rd_data (fifo_data),
		.empty   (fifo_empty),
		.overrun (overrun)
	);

	uart_tx u_uart_tx
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.tick       (tick),
		.cts_n      (cts_n),
		.fifo_data  (fifo_data),
		.fifo_empty (fifo_empty),
		.fifo_pop   (fifo_pop),
		.tx         (tx)
	);

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_defs.svh"

module uart_rx
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      tick,        // 16x oversampling strobe
	input  logic                      rx,          // async serial in
	output uart_echo_pkg::uart_byte_t rx_data,
	output logic                      rx_done,     // good byte for one clock
	output logic                      frame_err    // stop bit low for one clock
);
	import uart_echo_pkg::*;

	localparam int TPB = `UART_TICKS_PER_BIT;
	localparam int DB  = `UART_DATA_BITS;
	localparam int TW  = $clog2(TPB);
	localparam int BW  = $clog2(DB);

	logic [1:0]    rx_sync;    // two flop synchronizer
	logic          rx_s;
	rx_state_t     state;
	logic [TW-1:0] tick_cnt;
	logic [BW-1:0] bit_cnt;
	uart_byte_t    shift;      // lsb first shift in
	logic          mid_start;  // tick at centre of start bit
	logic          bit_mid;    // tick at centre of a data or stop bit

	////////////////////////////////////////////////////////////
	// input synchronizer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rx_sync <= 2'b11;   // idle line is high
		else
			rx_sync <= {rx_sync[0], rx};
	end

	assign rx_s = rx_sync[1];

	assign mid_start = tick && (tick_cnt == TW'(TPB / 2 - 1));   // 8th tick
	assign bit_mid   = tick && (tick_cnt == TW'(TPB - 1));       // 16th tick

	////////////////////////////////////////////////////////////
	// frame state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= RX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			rx_done   <= 1'b0;
			frame_err <= 1'b0;
		end
		else
		begin
			rx_done   <= 1'b0;   // pulses by default low
			frame_err <= 1'b0;
			if (tick)
			begin
				case (state)
					RX_IDLE:
					begin
						tick_cnt <= '0;
						if (!rx_s)
							state <= RX_START;   // possible start edge
					end
					RX_START:
					begin
						if (mid_start)
						begin
							tick_cnt <= '0;
							bit_cnt  <= '0;
							// line back high at centre means a glitch
							state    <= rx_s ? RX_IDLE : RX_DATA;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					RX_DATA:
					begin
						tick_cnt <= tick_cnt + 1'b1;   // wraps at TPB
						if (bit_mid)
						begin
							if (bit_cnt == BW'(DB - 1))
								state <= RX_STOP;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
					end
					RX_STOP:
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (bit_mid)
						begin
							state     <= RX_IDLE;
							rx_done   <= rx_s;    // stop high so the byte is good
							frame_err <= !rx_s;   // stop low so the byte is dropped
						end
					end
					default:
						state <= RX_IDLE;
				endcase
			end
		end
	end

	// data shift at each data bit centre
	always_ff @(posedge clk)
	begin
		if (bit_mid && state == RX_DATA)
			shift <= {rx_s, shift[DB-1:1]};
	end

	assign rx_data = shift;   // stable through stop state

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// one outcome per frame with the byte already settled
	a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
		(rx_done || frame_err) |-> !(rx_done && frame_err) && $stable(rx_data));

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_defs.svh"

module uart_tx
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      tick,
	input  logic                      cts_n,        // high holds off new frames
	input  uart_echo_pkg::uart_byte_t fifo_data,
	input  logic                      fifo_empty,
	output logic                      fifo_pop,     // one clock pulse that takes fifo_data
	output logic                      tx            // serial out with idle high
);
	import uart_echo_pkg::*;

	localparam int TPB = `UART_TICKS_PER_BIT;
	localparam int DB  = `UART_DATA_BITS;
	localparam int TW  = $clog2(TPB);
	localparam int BW  = $clog2(DB);

	tx_state_t     state;
	logic [TW-1:0] tick_cnt;
	logic [BW-1:0] bit_cnt;
	uart_byte_t    shift;
	logic          bit_end;    // last tick of current bit
	logic          shift_en;   // move next data bit to the line

	// start only from idle with data and clear to send
	assign fifo_pop = (state == TX_IDLE) && !fifo_empty && !cts_n;

	assign bit_end  = tick && (tick_cnt == TW'(TPB - 1));
	assign shift_en = bit_end &&
		((state == TX_START) || (state == TX_DATA && bit_cnt != BW'(DB - 1)));

	////////////////////////////////////////////////////////////
	// frame state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1;
		end
		else
		begin
			if (tick && state != TX_IDLE)
				tick_cnt <= tick_cnt + 1'b1;   // wraps every bit
			if (shift_en)
				tx <= shift[0];                // lsb first
			case (state)
				TX_IDLE:
				begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (fifo_pop)
					begin
						state <= TX_START;
						tx    <= 1'b0;   // start bit from the next clock
					end
				end
				TX_START:
				begin
					if (bit_end)
						state <= TX_DATA;
				end
				TX_DATA:
				begin
					if (bit_end)
					begin
						if (bit_cnt == BW'(DB - 1))
						begin
							state <= TX_STOP;
							tx    <= 1'b1;   // stop bit
						end
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				TX_STOP:
				begin
					if (bit_end)
						state <= TX_IDLE;   // may pop again right away
				end
				default:
				begin
					state <= TX_IDLE;
					tx    <= 1'b1;
				end
			endcase
		end
	end

	// load on pop and shift out at each bit boundary
	always_ff @(posedge clk)
	begin
		if (fifo_pop)
			shift <= fifo_data;
		else if (shift_en)
			shift <= shift >> 1;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// pop only while the line idles high, start bit on the next clock
	a_pop_idle: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_pop |-> tx ##1 !tx);

endmodule

`default_nettype wire

// File: testbench/tb_uart_echo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_defs.svh"

module tb_uart_echo;
	import uart_echo_pkg::*;

	localparam int BIT_CLKS = `UART_CLKS_PER_TICK * `UART_TICKS_PER_BIT;   // 64 clocks
	localparam int DB       = `UART_DATA_BITS;
	localparam int FD       = `UART_FIFO_DEPTH;
	localparam int NROWS    = 7;

	localparam logic [1:0] K_IDLE     = 2'd0;   // no stimulus, line must stay quiet
	localparam logic [1:0] K_ECHO     = 2'd1;
	localparam logic [1:0] K_BAD_STOP = 2'd2;   // first frame has a low stop bit
	localparam logic [1:0] K_GLITCH   = 2'd3;

	typedef struct packed
	{
		logic [1:0]       kind;
		logic             cts_n;   // held high while sending
		int               nsend;
		uart_byte_t [5:0] data;
		int               nexp;    // bytes expected back on tx
		uart_byte_t [5:0] exp;
		int               nfe;
		int               nov;
	} row_t;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       rx;
	logic       cts_n;
	logic       tx;
	logic       frame_err;
	logic       overrun;
	row_t       stim [NROWS];
	string      row_name [NROWS];
	uart_byte_t got_q [$];      // decoded tx bytes, arrival order
	int         stop_q [$];     // stop bit seen with each byte
	int         fe_cnt = 0;
	int         ov_cnt = 0;
	int         errors = 0;
	int         checks = 0;
	logic       mon_busy = 1'b0;
	int         mon_clk = 0;
	uart_byte_t mon_shift = '0;

	always #50 clk = ~clk;   // 100 ns period

	uart_echo_top u_uart_echo_top
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.cts_n     (cts_n),
		.tx        (tx),
		.frame_err (frame_err),
		.overrun   (overrun)
	);

	////////////////////////////////////////////////////////////
	// tx monitor and flag counters, on falling edges
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!rst_n)
			mon_busy = 1'b0;
		else if (!mon_busy)
		begin
			if (!tx)
			begin
				mon_busy = 1'b1;   // falling edge, maybe a start bit
				mon_clk  = 0;
			end
		end
		else
		begin
			mon_clk = mon_clk + 1;
			if (mon_clk == BIT_CLKS / 2)
			begin
				if (tx)
					mon_busy = 1'b0;   // high at centre, no frame
			end
			else if (mon_clk > BIT_CLKS / 2 && (mon_clk - BIT_CLKS / 2) % BIT_CLKS == 0)
			begin
				if ((mon_clk - BIT_CLKS / 2) / BIT_CLKS <= DB)
					mon_shift = {tx, mon_shift[DB-1:1]};   // lsb first
				else
				begin
					got_q.push_back(mon_shift);   // stop bit centre
					stop_q.push_back(tx ? 1 : 0);
					mon_busy = 1'b0;
				end
			end
		end
	end

	always @(negedge clk)
	begin
		if (rst_n && frame_err)
			fe_cnt = fe_cnt + 1;
		if (rst_n && overrun)
			ov_cnt = ov_cnt + 1;
	end

	////////////////////////////////////////////////////////////
	// compare helpers
	////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERR %0t %s expected %02h actual %02h", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp)
		begin
			errors++;
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// serial driver
	////////////////////////////////////////////////////////////

	task automatic drive_bit(input logic v);
		rx = v;
		repeat (BIT_CLKS) @(negedge clk);   // one bit, 64 clocks
	endtask

	task automatic send_frame(input uart_byte_t b, input logic bad_stop);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < DB; i++)
			drive_bit(b[i]);
		drive_bit(!bad_stop);
		if (bad_stop)
		begin
			drive_bit(1'b1);   // idle gap, low stop bit would look like a start
			drive_bit(1'b1);
		end
	endtask

	task automatic idle_bits(input int n);
		repeat (n * BIT_CLKS) @(negedge clk);
	endtask

	// poll on rising edges until n new bytes decoded, bounded
	task automatic wait_echoes(input int base, input int n);
		int t;
		int limit;
		t     = 0;
		limit = (n + 2) * 20 * BIT_CLKS;
		while (got_q.size() - base < n && t < limit)
		begin
			@(posedge clk);
			t++;
		end
		if (got_q.size() - base < n)
		begin
			errors++;
			$display("timeout at %0t: waited %0d clocks for %0d bytes on tx, got %0d",
				$time, t, n, got_q.size() - base);
		end
		@(negedge clk);   // back to the drive edge
	endtask

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////

	task automatic set_row(input int r, input string name, input logic [1:0] kind,
		input logic cts, input int nsend, input int nexp, input int nfe, input int nov);
		stim[r]       = '0;
		row_name[r]   = name;
		stim[r].kind  = kind;
		stim[r].cts_n = cts;
		stim[r].nsend = nsend;
		stim[r].nexp  = nexp;
		stim[r].nfe   = nfe;
		stim[r].nov   = nov;
	endtask

	task automatic build_table();
		int i;
		set_row(0, "reset idle", K_IDLE, 1'b0, 0, 0, 0, 0);
		set_row(1, "single byte 55", K_ECHO, 1'b0, 1, 1, 0, 0);
		set_row(2, "single byte a3", K_ECHO, 1'b0, 1, 1, 0, 0);
		set_row(3, "random burst", K_ECHO, 1'b0, 4, 4, 0, 0);
		set_row(4, "low stop bit", K_BAD_STOP, 1'b0, 2, 1, 1, 0);
		set_row(5, "start glitch", K_GLITCH, 1'b0, 0, 0, 0, 0);
		set_row(6, "cts hold and overrun", K_ECHO, 1'b1, 6, FD, 0, 6 - FD);   // fifo keeps FD
		stim[1].data[0] = 8'h55;
		stim[2].data[0] = 8'ha3;
		stim[4].data[0] = 8'h3c;   // dropped
		stim[4].data[1] = 8'h81;
		for (i = 0; i < 6; i++)
		begin
			stim[3].data[i] = uart_byte_t'($urandom);
			stim[6].data[i] = uart_byte_t'($urandom);
		end
		for (i = 0; i < NROWS; i++)
			stim[i].exp = stim[i].data;   // echo in order, first nexp
		stim[4].exp[0] = stim[4].data[1];   // only the good frame comes back
	endtask

	task automatic run_row(input int r);
		int base;
		int fe0;
		int ov0;
		int err0;
		int low;
		int i;
		base  = got_q.size();
		fe0   = fe_cnt;
		ov0   = ov_cnt;
		err0  = errors;
		low   = 0;
		cts_n = stim[r].cts_n;
		case (stim[r].kind)
			K_IDLE:
			begin
				for (i = 0; i < 20 * BIT_CLKS; i++)
				begin
					@(negedge clk);
					if (!tx)
						low++;
				end
				check_count("tx low clocks", 0, low);
			end
			K_GLITCH:
			begin
				rx = 1'b0;
				repeat (BIT_CLKS / 4) @(negedge clk);   // quarter bit
				rx = 1'b1;
			end
			default:
				for (i = 0; i < stim[r].nsend; i++)
					send_frame(stim[r].data[i], stim[r].kind == K_BAD_STOP && i == 0);
		endcase
		if (cts_n)
		begin
			idle_bits(12);
			check_count("tx bytes while cts_n high", 0, got_q.size() - base);
			check_count("overrun", stim[r].nov, ov_cnt - ov0);
			cts_n = 1'b0;   // release, fifo drains
		end
		wait_echoes(base, stim[r].nexp);
		idle_bits(12);   // nothing extra may follow
		check_count("tx byte count", stim[r].nexp, got_q.size() - base);
		for (i = 0; i < stim[r].nexp && base + i < got_q.size(); i++)
		begin
			check_byte("tx", stim[r].exp[i], got_q[base + i]);
			check_count("tx stop bit", 1, stop_q[base + i]);
		end
		check_count("frame_err", stim[r].nfe, fe_cnt - fe0);
		check_count("overrun", stim[r].nov, ov_cnt - ov0);
		$display("test %0d %s: %s", r, row_name[r], (errors == err0) ? "pass" : "fail");
	endtask

	initial
	begin
		int r;
		rst_n = 1'b0;
		rx    = 1'b1;   // idle line
		cts_n = 1'b0;
		void'($urandom(32'hbf8e_c727));
		build_table();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		for (r = 0; r < NROWS; r++)
			run_row(r);
		$display("tests %0d, checks %0d, errors %0d", NROWS, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
